// File: hw/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [127:0] lc3b_cacheline;

// address = {tag, index, offset}
typedef logic [7:0] lc3b_l2_tag;
typedef logic [3:0] lc3b_l2_index;
typedef logic [2:0] lc3b_l2_lru;

typedef struct packed {
    logic load_d;
    logic load_v;
    logic load_td;
    logic d_in;
    logic v_in;
} lc3b_way_ctl;

typedef struct packed {
    lc3b_way_ctl way0;
    lc3b_way_ctl way1;
    lc3b_way_ctl way2;
    lc3b_way_ctl way3;
    logic        load_lru;
} lc3b_l2_ctl;

typedef struct packed {
    logic hit;
    logic d_out;
} lc3b_way_state;

typedef struct packed {
    lc3b_way_state way0;
    lc3b_way_state way1;
    lc3b_way_state way2;
    lc3b_way_state way3;
} lc3b_l2_state;

typedef enum logic [1:0] {
    s_check,
    s_writeback,
    s_allocate
} lc3b_l2_fsm;

typedef enum logic [2:0] {
    addr_request = 3'd0,
    addr_way0    = 3'd1,
    addr_way1    = 3'd2,
    addr_way2    = 3'd3,
    addr_way3    = 3'd4
} lc3b_l2_addr_sel;

// bit 0 picks the half, bit 1 or bit 2 the way inside it
function automatic logic [1:0] plru_victim(input lc3b_l2_lru lru);
    if (!lru[0]) begin
        return {1'b0, lru[1]};
    end
    return {1'b1, lru[2]};
endfunction

endpackage : lc3b_types

// File: hw/l2_array.sv
`timescale 1ns/1ps

module l2_array
    import lc3b_types::*;
#(
    parameter int width = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             write,
    input  lc3b_l2_index     index,
    input  logic [width-1:0] datain,
    output logic [width-1:0] dataout
);

    logic [width-1:0] mem [16];

    // users that need no clearing tie rst low
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            mem[index] <= datain;
        end
    end

    assign dataout = mem[index];

endmodule : l2_array

// File: hw/l2_way.sv
`timescale 1ns/1ps

module l2_way
    import lc3b_types::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          load_d,
    input  logic          load_v,
    input  logic          load_td,
    input  lc3b_l2_index  index,
    input  logic          d_in,
    input  logic          v_in,
    input  lc3b_l2_tag    tag_in,
    input  lc3b_cacheline data_in,
    output logic          d_out,
    output logic          v_out,
    output lc3b_l2_tag    tag_out,
    output lc3b_cacheline data_out
);

    l2_array #(.width(1)) valid_array (
        .clk, .rst, .write(load_v), .index,
        .datain(v_in), .dataout(v_out)
    );

    l2_array #(.width(1)) dirty_array (
        .clk, .rst, .write(load_d), .index,
        .datain(d_in), .dataout(d_out)
    );

    // tag and data share one load
    l2_array #(.width(8)) tag_array (
        .clk, .rst(1'b0), .write(load_td), .index,
        .datain(tag_in), .dataout(tag_out)
    );

    l2_array #(.width(128)) data_array (
        .clk, .rst(1'b0), .write(load_td), .index,
        .datain(data_in), .dataout(data_out)
    );

endmodule : l2_way

// File: hw/l2_plru.sv
`timescale 1ns/1ps

module l2_plru
    import lc3b_types::*;
(
    input  lc3b_l2_lru lru_in,
    input  logic [1:0] hit_way,
    output logic [1:0] victim_way,
    output lc3b_l2_lru lru_next
);

    assign victim_way = plru_victim(lru_in);

    // point the tree away from the way just used
    always_comb begin
        lru_next = lru_in;
        lru_next[0] = ~hit_way[1];
        if (!hit_way[1]) begin
            lru_next[1] = ~hit_way[0];
        end else begin
            lru_next[2] = ~hit_way[0];
        end
    end

endmodule : l2_plru

// File: hw/l2_cache_datapath.sv
`timescale 1ns/1ps

module l2_cache_datapath
    import lc3b_types::*;
(
    input  logic            clk,
    input  logic            rst,
    input  lc3b_l2_ctl      ctl,
    input  logic            fill_from_mem,
    input  logic [1:0]      touch_way,
    input  lc3b_l2_addr_sel pmemaddr_sel,
    input  lc3b_word        mem_address,
    input  lc3b_cacheline   l2_wdata,
    input  lc3b_cacheline   pmem_rdata,
    output lc3b_l2_state    state,
    output logic [1:0]      victim_way,
    output logic            victim_dirty,
    output lc3b_l2_lru      lru_next,
    output lc3b_cacheline   l2_mem_rdata,
    output lc3b_word        pmem_address,
    output lc3b_cacheline   pmem_wdata
);

    lc3b_l2_tag    req_tag;
    lc3b_l2_index  req_index;
    lc3b_way_ctl   way_ctl [4];
    logic [3:0]    v_out;
    logic [3:0]    d_out;
    logic [3:0]    hit;
    lc3b_l2_tag    tag_out [4];
    lc3b_cacheline data_out [4];
    lc3b_cacheline fill_line;
    lc3b_l2_lru    lru_cur;

    assign req_tag = mem_address[15:8];
    assign req_index = mem_address[7:4];

    assign way_ctl[0] = ctl.way0;
    assign way_ctl[1] = ctl.way1;
    assign way_ctl[2] = ctl.way2;
    assign way_ctl[3] = ctl.way3;

    // whole-line fill from memory, or the arbiter's line on a write hit
    assign fill_line = fill_from_mem ? pmem_rdata : l2_wdata;

    for (genvar w = 0; w < 4; w++) begin : g_way
        l2_way way_inst (
            .clk, .rst,
            .load_d(way_ctl[w].load_d), .load_v(way_ctl[w].load_v),
            .load_td(way_ctl[w].load_td), .index(req_index),
            .d_in(way_ctl[w].d_in), .v_in(way_ctl[w].v_in),
            .tag_in(req_tag), .data_in(fill_line),
            .d_out(d_out[w]), .v_out(v_out[w]),
            .tag_out(tag_out[w]), .data_out(data_out[w])
        );
        assign hit[w] = v_out[w] && (tag_out[w] == req_tag);
    end

    l2_array #(.width(3)) lru_array (
        .clk, .rst, .write(ctl.load_lru), .index(req_index),
        .datain(lru_next), .dataout(lru_cur)
    );

    l2_plru plru (
        .lru_in(lru_cur), .hit_way(touch_way),
        .victim_way, .lru_next
    );

    assign state = '{
        way0: '{hit: hit[0], d_out: d_out[0]},
        way1: '{hit: hit[1], d_out: d_out[1]},
        way2: '{hit: hit[2], d_out: d_out[2]},
        way3: '{hit: hit[3], d_out: d_out[3]}
    };

    assign victim_dirty = v_out[victim_way] && d_out[victim_way];

    assign l2_mem_rdata = data_out[touch_way];
    assign pmem_wdata = data_out[touch_way];

    always_comb begin
        unique case (pmemaddr_sel)
            addr_way0: pmem_address = {tag_out[0], req_index, 4'h0};
            addr_way1: pmem_address = {tag_out[1], req_index, 4'h0};
            addr_way2: pmem_address = {tag_out[2], req_index, 4'h0};
            addr_way3: pmem_address = {tag_out[3], req_index, 4'h0};
            default:   pmem_address = {req_tag, req_index, 4'h0};
        endcase
    end

    // a tag lives in at most one way of a set
    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        (|v_out) |-> $onehot0(hit))
        else $error("more than one way hit at address %h", mem_address);

endmodule : l2_cache_datapath

// File: hw/l2_cache_control.sv
`timescale 1ns/1ps

module l2_cache_control
    import lc3b_types::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_read,
    input  logic            mem_write,
    input  lc3b_l2_state    state,
    input  logic [1:0]      victim_way,
    input  logic            victim_dirty,
    input  lc3b_l2_lru      lru_next,
    input  logic            pmem_resp,
    output lc3b_l2_ctl      ctl,
    output logic            fill_from_mem,
    output logic [1:0]      touch_way,
    output lc3b_l2_addr_sel pmemaddr_sel,
    output logic            mem_resp,
    output logic            pmem_read,
    output logic            pmem_write
);

    lc3b_l2_fsm      fsm;
    lc3b_l2_fsm      fsm_next;
    lc3b_way_ctl     way_ctl [4];
    logic            load_lru;
    logic [3:0]      hits;
    logic [1:0]      hit_way;
    logic            request;
    lc3b_l2_addr_sel victim_sel;

    assign hits = {state.way3.hit, state.way2.hit, state.way1.hit, state.way0.hit};
    assign request = mem_read | mem_write;

    // one-hot hit to way number
    always_comb begin
        hit_way = 2'd0;
        for (int w = 0; w < 4; w++) begin
            if (hits[w]) begin
                hit_way = 2'(w);
            end
        end
    end

    always_comb begin
        unique case (victim_way)
            2'd0: victim_sel = addr_way0;
            2'd1: victim_sel = addr_way1;
            2'd2: victim_sel = addr_way2;
            default: victim_sel = addr_way3;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fsm <= s_check;
        end else begin
            fsm <= fsm_next;
        end
    end

    always_comb begin
        fsm_next = fsm;
        for (int w = 0; w < 4; w++) begin
            way_ctl[w] = '0;
        end
        load_lru = 1'b0;
        fill_from_mem = 1'b1;
        touch_way = victim_way;
        pmemaddr_sel = addr_request;
        mem_resp = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;

        unique case (fsm)
            s_check: begin
                if (request && |hits) begin
                    touch_way = hit_way;
                    mem_resp = 1'b1;
                    load_lru = 1'b1;
                    if (mem_write) begin
                        fill_from_mem = 1'b0;
                        way_ctl[hit_way].load_td = 1'b1;
                        way_ctl[hit_way].load_d = 1'b1;
                        way_ctl[hit_way].d_in = 1'b1;
                    end
                end else if (request) begin
                    fsm_next = victim_dirty ? s_writeback : s_allocate;
                end
            end
            s_writeback: begin
                pmem_write = 1'b1;
                pmemaddr_sel = victim_sel;
                if (pmem_resp) begin
                    fsm_next = s_allocate;
                end
            end
            s_allocate: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    // new line lands clean in the victim way
                    way_ctl[victim_way].load_td = 1'b1;
                    way_ctl[victim_way].load_v = 1'b1;
                    way_ctl[victim_way].v_in = 1'b1;
                    way_ctl[victim_way].load_d = 1'b1;
                    way_ctl[victim_way].d_in = 1'b0;
                    load_lru = 1'b1;
                    fsm_next = s_check;
                end
            end
            default: fsm_next = s_check;
        endcase
    end

    assign ctl = '{
        way0: way_ctl[0],
        way1: way_ctl[1],
        way2: way_ctl[2],
        way3: way_ctl[3],
        load_lru: load_lru
    };

    a_pmem_excl: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    a_resp_in_check: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_resp) |-> fsm == s_check)
        else $error("mem_resp raised in state %s", fsm.name());

endmodule : l2_cache_control

// File: hw/l2_cache.sv
`timescale 1ns/1ps

module l2_cache
    import lc3b_types::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          mem_read,
    input  logic          mem_write,
    input  lc3b_word      mem_address,
    input  lc3b_cacheline l2_wdata,
    output lc3b_cacheline l2_mem_rdata,
    output logic          mem_resp,
    output logic          pmem_read,
    output logic          pmem_write,
    output lc3b_word      pmem_address,
    output lc3b_cacheline pmem_wdata,
    input  lc3b_cacheline pmem_rdata,
    input  logic          pmem_resp
);

    lc3b_l2_ctl      ctl;
    lc3b_l2_state    state;
    logic            fill_from_mem;
    logic [1:0]      touch_way;
    lc3b_l2_addr_sel pmemaddr_sel;
    logic [1:0]      victim_way;
    logic            victim_dirty;
    lc3b_l2_lru      lru_next;

    l2_cache_datapath datapath (
        .clk, .rst, .ctl, .fill_from_mem, .touch_way, .pmemaddr_sel,
        .mem_address, .l2_wdata, .pmem_rdata,
        .state, .victim_way, .victim_dirty, .lru_next,
        .l2_mem_rdata, .pmem_address, .pmem_wdata
    );

    l2_cache_control control (
        .clk, .rst, .mem_read, .mem_write,
        .state, .victim_way, .victim_dirty, .lru_next, .pmem_resp,
        .ctl, .fill_from_mem, .touch_way, .pmemaddr_sel,
        .mem_resp, .pmem_read, .pmem_write
    );

endmodule : l2_cache

// File: verif/pmem_model.sv
`timescale 1ns/1ps

module pmem_model
    import lc3b_types::*;
#(
    parameter int latency = 3
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          pmem_read,
    input  logic          pmem_write,
    input  lc3b_word      pmem_address,
    input  lc3b_cacheline pmem_wdata,
    output lc3b_cacheline pmem_rdata,
    output logic          pmem_resp
);

    lc3b_cacheline mem [lc3b_word];
    lc3b_word      line_addr;
    int            wait_count;
    int            access_seq;

    // visible to the testbench
    int            read_count;
    int            write_count;
    int            read_seq;
    int            write_seq;
    lc3b_word      last_read_addr;
    lc3b_word      last_write_addr;
    lc3b_cacheline last_write_data;

    assign line_addr = {pmem_address[15:4], 4'h0};

    always @(posedge clk) begin
        if (rst) begin
            pmem_resp <= 1'b0;
            pmem_rdata <= '0;
            wait_count <= 0;
            access_seq <= 0;
            read_count <= 0;
            write_count <= 0;
            read_seq <= 0;
            write_seq <= 0;
        end else begin
            pmem_resp <= 1'b0;
            // the resp cycle itself never starts a new count
            if ((pmem_read || pmem_write) && !pmem_resp) begin
                if (wait_count == latency - 1) begin
                    wait_count <= 0;
                    pmem_resp <= 1'b1;
                    access_seq <= access_seq + 1;
                    if (pmem_write) begin
                        mem[line_addr] = pmem_wdata;
                        write_count <= write_count + 1;
                        write_seq <= access_seq + 1;
                        last_write_addr <= pmem_address;
                        last_write_data <= pmem_wdata;
                    end else begin
                        // untouched lines hold their own line address
                        pmem_rdata <= mem.exists(line_addr) ? mem[line_addr] : {8{line_addr}};
                        read_count <= read_count + 1;
                        read_seq <= access_seq + 1;
                        last_read_addr <= pmem_address;
                    end
                end else begin
                    wait_count <= wait_count + 1;
                end
            end
        end
    end

endmodule : pmem_model

// File: verif/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb
    import lc3b_types::*;
;

    localparam int resp_timeout = 40;

    logic          clk;
    logic          rst;
    logic          mem_read;
    logic          mem_write;
    lc3b_word      mem_address;
    lc3b_cacheline l2_wdata;
    lc3b_cacheline l2_mem_rdata;
    logic          mem_resp;
    logic          pmem_read;
    logic          pmem_write;
    lc3b_word      pmem_address;
    lc3b_cacheline pmem_wdata;
    lc3b_cacheline pmem_rdata;
    logic          pmem_resp;

    int error_count = 0;
    int check_total = 0;

    // what a read must return, and the expected cache contents
    lc3b_cacheline ref_mem [lc3b_word];
    lc3b_l2_tag    model_tag [16][4];
    logic          model_valid [16][4];
    logic          model_dirty [16][4];
    lc3b_l2_lru    model_lru [16];

    l2_cache l2_cache_inst (
        .clk, .rst, .mem_read, .mem_write, .mem_address, .l2_wdata,
        .l2_mem_rdata, .mem_resp, .pmem_read, .pmem_write, .pmem_address,
        .pmem_wdata, .pmem_rdata, .pmem_resp
    );

    pmem_model #(.latency(3)) pmem_inst (
        .clk, .rst, .pmem_read, .pmem_write, .pmem_address,
        .pmem_wdata, .pmem_rdata, .pmem_resp
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_line(input string name, input lc3b_cacheline expected,
                              input lc3b_cacheline actual);
        check_total++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input lc3b_word expected,
                              input lc3b_word actual);
        check_total++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_total++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        check_total++;
        if (actual != expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors", check_total, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    function automatic lc3b_cacheline ref_line(input lc3b_word addr);
        lc3b_word line;
        line = {addr[15:4], 4'h0};
        if (ref_mem.exists(line)) begin
            ref_line = ref_mem[line];
        end else begin
            ref_line = {8{line}};
        end
    endfunction

    function automatic logic [1:0] victim_of(input lc3b_l2_lru lru);
        if (!lru[0]) begin
            victim_of = lru[1] ? 2'd1 : 2'd0;
        end else begin
            victim_of = lru[2] ? 2'd3 : 2'd2;
        end
    endfunction

    function automatic lc3b_l2_lru touched_lru(input lc3b_l2_lru lru, input logic [1:0] way);
        lc3b_l2_lru next;
        next = lru;
        next[0] = (way < 2'd2);
        if (way < 2'd2) begin
            next[1] = (way == 2'd0);
        end else begin
            next[2] = (way == 2'd2);
        end
        touched_lru = next;
    endfunction

    // one request through the cache, checked against the model
    task automatic access_line(input string name, input logic is_write, input lc3b_word addr,
                               input lc3b_cacheline wdata, output lc3b_cacheline rdata);
        lc3b_l2_index  s;
        lc3b_l2_tag    t;
        lc3b_word      line;
        logic          hit;
        logic [1:0]    way;
        logic          wb;
        lc3b_word      wb_addr;
        lc3b_cacheline wb_data;
        lc3b_cacheline exp_data;
        int            reads0;
        int            writes0;
        int            cycles;
        s = addr[7:4];
        t = addr[15:8];
        line = {addr[15:4], 4'h0};
        hit = 1'b0;
        way = 2'd0;
        wb = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        for (int w = 0; w < 4; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == t) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        if (!hit) begin
            way = victim_of(model_lru[s]);
            wb = model_valid[s][way] && model_dirty[s][way];
            wb_addr = {model_tag[s][way], s, 4'h0};
            wb_data = ref_line(wb_addr);
            model_tag[s][way] = t;
            model_valid[s][way] = 1'b1;
            model_dirty[s][way] = 1'b0;
        end
        model_lru[s] = touched_lru(model_lru[s], way);
        exp_data = ref_line(addr);
        if (is_write) begin
            model_dirty[s][way] = 1'b1;
            ref_mem[line] = wdata;
        end
        reads0 = pmem_inst.read_count;
        writes0 = pmem_inst.write_count;

        @(negedge clk);
        mem_address = addr;
        l2_wdata = wdata;
        mem_read = !is_write;
        mem_write = is_write;
        cycles = 0;
        #10;
        while (!mem_resp && cycles < resp_timeout) begin
            @(negedge clk);
            #10;
            cycles++;
        end
        rdata = l2_mem_rdata;
        if (!mem_resp) begin
            $display("timeout: %s got no mem_resp for address %h within %0d cycles",
                     name, addr, resp_timeout);
            error_count++;
            finish_run();
        end else begin
            @(negedge clk);
            mem_read = 1'b0;
            mem_write = 1'b0;
            check_count({name, " pmem reads"}, hit ? 0 : 1, pmem_inst.read_count - reads0);
            check_count({name, " pmem writes"}, wb ? 1 : 0, pmem_inst.write_count - writes0);
            if (hit) begin
                check_bit({name, " resp in first cycle"}, 1'b1, cycles == 0);
            end else begin
                check_word({name, " fill address"}, line, pmem_inst.last_read_addr);
            end
            if (wb) begin
                check_word({name, " writeback address"}, wb_addr, pmem_inst.last_write_addr);
                check_line({name, " writeback data"}, wb_data, pmem_inst.last_write_data);
                check_bit({name, " writeback before fill"}, 1'b1,
                          pmem_inst.write_seq < pmem_inst.read_seq);
            end
            if (!is_write) begin
                check_line({name, " data"}, exp_data, rdata);
            end
        end
    endtask

    task automatic reset_test();
        lc3b_cacheline d;
        #10;
        check_bit("reset mem_resp", 1'b0, mem_resp);
        check_bit("reset pmem_read", 1'b0, pmem_read);
        check_bit("reset pmem_write", 1'b0, pmem_write);
        access_line("first read", 1'b0, 16'h1234, '0, d);
    endtask

    task automatic read_repeat_test();
        lc3b_cacheline first;
        lc3b_cacheline again;
        access_line("read miss", 1'b0, 16'h2340, '0, first);
        access_line("read hit", 1'b0, 16'h2344, '0, again);
        check_line("first read line", {8{16'h2340}}, first);
        check_line("repeat read line", {8{16'h2340}}, again);
    endtask

    task automatic write_hit_test();
        lc3b_cacheline d;
        lc3b_cacheline pattern;
        int            reads0;
        pattern = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
        access_line("write hit fill", 1'b0, 16'h3450, '0, d);
        reads0 = pmem_inst.read_count;
        access_line("write hit", 1'b1, 16'h3450, pattern, d);
        access_line("write hit readback", 1'b0, 16'h3458, '0, d);
        check_line("written line", pattern, d);
        check_count("write hit traffic", 0, pmem_inst.read_count - reads0);
    endtask

    task automatic plru_order_test();
        lc3b_cacheline d;
        lc3b_l2_tag    evicted;
        for (int i = 0; i < 4; i++) begin
            access_line("plru fill", 1'b0, {8'(8'h10 + i), 4'h6, 4'h0}, '0, d);
        end
        access_line("plru touch", 1'b0, 16'h1360, '0, d);
        access_line("plru touch", 1'b0, 16'h1060, '0, d);
        access_line("plru touch", 1'b0, 16'h1260, '0, d);
        evicted = model_tag[6][victim_of(model_lru[6])];
        access_line("plru new tag", 1'b0, 16'h1460, '0, d);
        // survivors first, so the evicted tag is the only miss
        for (int i = 0; i < 4; i++) begin
            if (8'(8'h10 + i) != evicted) begin
                access_line("plru survivor", 1'b0, {8'(8'h10 + i), 4'h6, 4'h0}, '0, d);
            end
        end
        access_line("plru evicted", 1'b0, {evicted, 4'h6, 4'h0}, '0, d);
    endtask

    task automatic eviction_test();
        lc3b_cacheline d;
        int            writes0;
        for (int i = 0; i < 4; i++) begin
            access_line("dirty fill", 1'b1, {8'(8'h20 + i), 4'h9, 4'h0},
                        {16{8'(8'ha0 + i)}}, d);
        end
        writes0 = pmem_inst.write_count;
        access_line("dirty evict", 1'b0, 16'h2490, '0, d);
        check_count("dirty evict writes", 1, pmem_inst.write_count - writes0);
        writes0 = pmem_inst.write_count;
        for (int i = 0; i < 5; i++) begin
            access_line("clean evict", 1'b0, {8'(8'h30 + i), 4'ha, 4'h0}, '0, d);
        end
        check_count("clean evict writes", 0, pmem_inst.write_count - writes0);
    endtask

    task automatic random_test();
        int            seed;
        int            r;
        lc3b_l2_index  set_idx;
        lc3b_l2_tag    tag;
        lc3b_cacheline wdata;
        lc3b_cacheline d;
        seed = 32'hc0b75aa8;
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            set_idx = 4'(1 + (r & 32'hff) % 3);
            tag = 8'(8'h40 + ((r >> 8) & 32'hff) % 6);
            wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
            access_line($sformatf("random %0d", i), r[16], {tag, set_idx, r[23:20]}, wdata, d);
        end
    endtask

    initial begin
        rst = 1'b1;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        l2_wdata = '0;
        for (int s = 0; s < 16; s++) begin
            model_lru[s] = '0;
            for (int w = 0; w < 4; w++) begin
                model_tag[s][w] = '0;
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_test();
        read_repeat_test();
        write_hit_test();
        plru_order_test();
        eviction_test();
        random_test();
        finish_run();
    end

endmodule : l2_cache_tb

// File: l2_cache.f
hw/lc3b_types.sv
hw/l2_array.sv
hw/l2_way.sv
hw/l2_plru.sv
hw/l2_cache_datapath.sv
hw/l2_cache_control.sv
hw/l2_cache.sv
verif/pmem_model.sv
verif/l2_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module l2_cache_tb -f l2_cache.f
./obj_dir/Vl2_cache_tb | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
